// File: common/display_params.svh
// timing, sprite and colour constants for the sprite display pipeline
// included by the package and by any module that needs sizes or timing
`ifndef DISPLAY_PARAMS_SVH
`define DISPLAY_PARAMS_SVH

// 640x480 horizontal timing, in pixels
`define H_RES       640
`define H_FP        16
`define H_SYNC      96
`define H_BP        48

// vertical timing, in lines
`define V_RES       480
`define V_FP        10
`define V_SYNC      2
`define V_BP        33

`define SYNC_ACTIVE 1'b0    // sync pulses active low
`define CORDW       16      // signed coordinate width

`define SPR_W       8       // bitmap width
`define SPR_H       8       // bitmap height
`define SPR_SCALE   1       // 2^1 = 2x, drawn 16x16
`define CIDXW       4       // colour index width

`define CHANW       4       // bits per channel
`define COLRW       12      // three channels

`define PIPE_LAT    3       // counter position to compositor input, in cycles

`endif

// File: common/sprite_pkg.sv
// shared types for the sprite display pipeline
// modules pick these up with a wildcard import in their header
`include "display_params.svh"

package sprite_pkg;

    typedef logic signed [`CORDW-1:0] coord_t;  // screen coordinate, may go negative

    // sync and strobes from the display timing
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;       // active area
        logic line;     // sx == 0, every line
        logic frame;    // first blank line after active area
    } sync_t;

    typedef struct packed {
        logic [`CHANW-1:0] r;
        logic [`CHANW-1:0] g;
        logic [`CHANW-1:0] b;
    } colr_t;

    // wishbone classic, host side
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [7:0]  adr;
        logic [15:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [15:0] dat_r;
    } wb_rsp_t;

    // live sprite config, swapped in at frame start
    typedef struct packed {
        coord_t             sprx;
        coord_t             spry;
        colr_t              bg;
        logic [`CIDXW-1:0]  trans_idx;
    } spr_cfg_t;

    // shared write port for bitmap and palette, each takes the low bits it needs
    typedef struct packed {
        logic        en;
        logic [5:0]  addr;
        logic [11:0] data;
    } mem_wr_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_X,
        ST_DRAW,
        ST_LINE_DONE
    } eng_state_e;

    // register map, palette at 0x10-0x1f, bitmap at 0x40-0x7f
    typedef enum logic [7:0] {
        REG_SPRX  = 8'h00,
        REG_SPRY  = 8'h01,
        REG_BG    = 8'h02,
        REG_TRANS = 8'h03
    } reg_addr_e;

endpackage

// File: display/display_timing.sv
// 640x480 display timing: pixel and line counters over the full 800x525 frame
// sync, de and strobes decode straight from the counters, same cycle as sx/sy
`include "display_params.svh"

module display_timing import sprite_pkg::*; (
    input  logic   clk_pix,
    input  logic   rst_pix,
    output coord_t sx,      // horizontal position
    output coord_t sy,      // vertical position
    output sync_t  sync
);

    localparam int H_TOTAL = `H_RES + `H_FP + `H_SYNC + `H_BP;  // 800
    localparam int V_TOTAL = `V_RES + `V_FP + `V_SYNC + `V_BP;  // 525
    localparam int HS_STA  = `H_RES + `H_FP;
    localparam int HS_END  = HS_STA + `H_SYNC;
    localparam int VS_STA  = `V_RES + `V_FP;
    localparam int VS_END  = VS_STA + `V_SYNC;

    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            sx <= '0;  // restart at first active pixel
            sy <= '0;
        end else if (sx == coord_t'(H_TOTAL - 1)) begin
            sx <= '0;
            if (sy == coord_t'(V_TOTAL - 1)) begin
                sy <= '0;  // wrap frame
            end else begin
                sy <= sy + coord_t'(1);
            end
        end else begin
            sx <= sx + coord_t'(1);
        end
    end

    always_comb begin
        sync.hsync = (sx >= HS_STA && sx < HS_END) ? `SYNC_ACTIVE : ~`SYNC_ACTIVE;
        sync.vsync = (sy >= VS_STA && sy < VS_END) ? `SYNC_ACTIVE : ~`SYNC_ACTIVE;
        sync.de    = (sx < `H_RES) && (sy < `V_RES);
        sync.line  = (sx == 0);
        sync.frame = (sx == 0) && (sy == `V_RES);  // start of vertical blank
    end

endmodule

// File: source/wb_regs.sv
// wishbone classic slave: register map, shadow and live config, memory windows
// one ack per access; shadow copied to live on the frame strobe
`include "display_params.svh"

module wb_regs import sprite_pkg::*; (
    input  logic     clk_pix,
    input  logic     rst_pix,
    input  wb_req_t  wb_req,
    output wb_rsp_t  wb_rsp,
    input  sync_t    sync,
    output spr_cfg_t cfg,       // live config
    output mem_wr_t  bmp_wr,
    output mem_wr_t  pal_wr
);

    // sprite starts off screen to the right
    localparam spr_cfg_t CFG_RST = '{
        sprx:      coord_t'(`H_RES),
        spry:      '0,
        bg:        '0,
        trans_idx: '0
    };

    spr_cfg_t    shadow;
    logic        req, held, hit;
    logic        in_pal, in_bmp;
    logic [15:0] rd_data;

    always_comb begin
        req    = wb_req.cyc && wb_req.stb;
        hit    = req && !held;                    // first cycle of an access
        in_pal = (wb_req.adr[7:4] == 4'h1);       // 0x10-0x1f
        in_bmp = (wb_req.adr[7:6] == 2'b01);      // 0x40-0x7f
        case (wb_req.adr)
            REG_SPRX:  rd_data = shadow.sprx;
            REG_SPRY:  rd_data = shadow.spry;
            REG_BG:    rd_data = 16'(shadow.bg);
            REG_TRANS: rd_data = 16'(shadow.trans_idx);
            default:   rd_data = '0;  // memories read as zero
        endcase
    end

    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            held   <= 1'b0;
            wb_rsp <= '0;
            bmp_wr <= '0;
            pal_wr <= '0;
            shadow <= CFG_RST;
            cfg    <= CFG_RST;
        end else begin
            held       <= req;  // no second ack while stb held
            wb_rsp.ack <= hit;
            if (hit) begin
                wb_rsp.dat_r <= rd_data;
            end
            // memory write pulses, same cycle as ack
            bmp_wr.en   <= hit && wb_req.we && in_bmp;
            bmp_wr.addr <= wb_req.adr[5:0];
            bmp_wr.data <= wb_req.dat_w[11:0];
            pal_wr.en   <= hit && wb_req.we && in_pal;
            pal_wr.addr <= {2'b00, wb_req.adr[3:0]};
            pal_wr.data <= wb_req.dat_w[11:0];
            if (hit && wb_req.we) begin
                case (wb_req.adr)
                    REG_SPRX:  shadow.sprx      <= coord_t'(wb_req.dat_w);
                    REG_SPRY:  shadow.spry      <= coord_t'(wb_req.dat_w);
                    REG_BG:    shadow.bg        <= colr_t'(wb_req.dat_w[`COLRW-1:0]);
                    REG_TRANS: shadow.trans_idx <= wb_req.dat_w[`CIDXW-1:0];
                    default:   ;
                endcase
            end
            if (sync.frame) begin
                cfg <= shadow;  // in blanking, so no tearing
            end
        end
    end

endmodule

// File: sprite/sprite_engine.sv
// per-line sprite engine: picks the bitmap row on line and steps columns
// across the scaled span; address and draw flag registered one cycle after sx
`include "display_params.svh"

module sprite_engine import sprite_pkg::*; (
    input  logic       clk_pix,
    input  logic       rst_pix,
    input  coord_t     sx,
    input  coord_t     sy,
    input  sync_t      sync,
    input  spr_cfg_t   cfg,
    output logic [5:0] bmp_addr,   // row*8 + column
    output logic       draw
);

    localparam int SPR_DRAWW = `SPR_W << `SPR_SCALE;  // drawn width
    localparam int SPR_DRAWH = `SPR_H << `SPR_SCALE;
    localparam int ROWW      = $clog2(`SPR_H);
    localparam int XSW       = $clog2(`SPR_W) + `SPR_SCALE;  // column plus scale phase

    eng_state_e       st_q, st_d;
    logic [ROWW-1:0]  row_q, row_d, cur_row;
    logic [XSW-1:0]   xs_q, xs_d, xs_cur;  // scaled x offset within sprite
    logic [XSW-1:0]   xs_start;
    coord_t           dy, xoff;
    logic             in_range, start_hit, armed, drawing, last;

    always_comb begin
        dy       = sy - cfg.spry;
        xoff     = -cfg.sprx;  // only used when sprx is negative
        in_range = (dy >= 0) && (dy < SPR_DRAWH) && (cfg.sprx > -SPR_DRAWW);
        // left clip: start at sx 0 with column and phase already advanced
        start_hit = (cfg.sprx < 0) ? (sx == 0) : (sx == cfg.sprx);
        xs_start  = (cfg.sprx < 0) ? xoff[XSW-1:0] : '0;
    end

    always_comb begin
        st_d    = st_q;
        row_d   = row_q;
        xs_d    = xs_q;
        cur_row = row_q;
        xs_cur  = xs_q;
        armed   = (st_q == ST_WAIT_X);
        drawing = 1'b0;
        last    = 1'b0;
        if (sync.line) begin  // new line, recheck vertical hit
            armed   = in_range;
            cur_row = dy[`SPR_SCALE +: ROWW];
            row_d   = cur_row;
            st_d    = in_range ? ST_WAIT_X : ST_IDLE;
        end
        if (armed && start_hit) begin
            drawing = 1'b1;
            xs_cur  = xs_start;
        end else if (st_q == ST_DRAW) begin
            drawing = 1'b1;
        end
        if (drawing) begin
            last = (xs_cur == XSW'(SPR_DRAWW - 1)) || (sx >= coord_t'(`H_RES - 1));
            st_d = last ? ST_LINE_DONE : ST_DRAW;  // done waits for next line
            xs_d = xs_cur + XSW'(1);
        end
    end

    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            st_q <= ST_IDLE;
            draw <= 1'b0;
        end else begin
            st_q <= st_d;
            draw <= drawing && (sx < `H_RES);
        end
        row_q    <= row_d;
        xs_q     <= xs_d;
        bmp_addr <= {cur_row, xs_cur[XSW-1:`SPR_SCALE]};  // drop scale phase
    end

endmodule

// File: sprite/sprite_bitmap.sv
// 8x8 sprite bitmap of colour indices, host write port and engine read port
// read is registered and the draw flag travels with it
`include "display_params.svh"

module sprite_bitmap import sprite_pkg::*; (
    input  logic              clk_pix,
    input  mem_wr_t           wr,        // from wishbone side
    input  logic [5:0]        rd_addr,
    input  logic              draw,
    output logic [`CIDXW-1:0] cidx,
    output logic              draw_q     // draw delayed to match cidx
);

    localparam int DEPTH = `SPR_W * `SPR_H;  // 64 pixels

    logic [`CIDXW-1:0] bmp_mem [DEPTH];

    always_ff @(posedge clk_pix) begin
        if (wr.en) begin
            bmp_mem[wr.addr] <= wr.data[`CIDXW-1:0];  // low bits only
        end
    end

    // engine read, one cycle
    always_ff @(posedge clk_pix) begin
        cidx   <= bmp_mem[rd_addr];
        draw_q <= draw;
    end

endmodule

// File: source/palette_clut.sv
// 16-entry colour lookup table, 12-bit colours
// host writes through the shared port, pixel path reads with one cycle latency
`include "display_params.svh"

module palette_clut import sprite_pkg::*; (
    input  logic              clk_pix,
    input  mem_wr_t           wr,
    input  logic [`CIDXW-1:0] cidx,
    output colr_t             colr
);

    localparam int DEPTH = 1 << `CIDXW;

    colr_t pal_mem [DEPTH];

    always_ff @(posedge clk_pix) begin
        if (wr.en) begin
            pal_mem[wr.addr[`CIDXW-1:0]] <= colr_t'(wr.data[`COLRW-1:0]);
        end
    end

    always_ff @(posedge clk_pix) begin
        colr <= pal_mem[cidx];  // registered read
    end

endmodule

// File: source/pixel_compose.sv
// final pixel stage: transparency, sprite over background, blanking
// sync delayed to line up with the palette output, then all outputs registered
`include "display_params.svh"

module pixel_compose import sprite_pkg::*; (
    input  logic              clk_pix,
    input  logic              rst_pix,
    input  sync_t             sync,
    input  spr_cfg_t          cfg,
    input  logic [`CIDXW-1:0] cidx,
    input  logic              draw_q,
    input  colr_t             colr,
    output logic              hsync,
    output logic              vsync,
    output logic              de,
    output logic [`CHANW-1:0] r,
    output logic [`CHANW-1:0] g,
    output logic [`CHANW-1:0] b
);

    localparam sync_t SYNC_IDLE = '{
        hsync: ~`SYNC_ACTIVE,
        vsync: ~`SYNC_ACTIVE,
        default: 1'b0
    };

    sync_t sync_d [`PIPE_LAT];  // sync delay line
    sync_t sync_a;              // aligned with colr
    logic  opaque_q;
    colr_t paint, pix;

    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            for (int i = 0; i < `PIPE_LAT; i++) begin
                sync_d[i] <= SYNC_IDLE;
            end
            opaque_q <= 1'b0;
        end else begin
            sync_d[0] <= sync;
            for (int i = 1; i < `PIPE_LAT; i++) begin
                sync_d[i] <= sync_d[i-1];
            end
            opaque_q <= draw_q && (cidx != cfg.trans_idx);  // one stage ahead of colr
        end
    end

    always_comb begin
        sync_a = sync_d[`PIPE_LAT-1];
        paint  = opaque_q ? colr : cfg.bg;
        pix    = sync_a.de ? paint : '0;  // black in blanking
    end

    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            hsync <= ~`SYNC_ACTIVE;
            vsync <= ~`SYNC_ACTIVE;
            de    <= 1'b0;
            r     <= '0;
            g     <= '0;
            b     <= '0;
        end else begin
            hsync <= sync_a.hsync;
            vsync <= sync_a.vsync;
            de    <= sync_a.de;
            r     <= pix.r;
            g     <= pix.g;
            b     <= pix.b;
        end
    end

endmodule

// File: source/sprite_display_top.sv
// top level of the single-sprite display, wishbone in and 12-bit video out
// wires timing, registers, engine, bitmap, palette and compositor together
`include "display_params.svh"

module sprite_display_top import sprite_pkg::*; (
    input  logic              clk_pix,
    input  logic              rst_pix,
    input  wb_req_t           wb_req,
    output wb_rsp_t           wb_rsp,
    output logic              hsync,
    output logic              vsync,
    output logic              de,
    output logic [`CHANW-1:0] r,
    output logic [`CHANW-1:0] g,
    output logic [`CHANW-1:0] b
);

    coord_t            sx, sy;
    sync_t             sync;
    spr_cfg_t          cfg;
    mem_wr_t           bmp_wr, pal_wr;
    logic [5:0]        bmp_addr;
    logic              draw, draw_q;
    logic [`CIDXW-1:0] cidx;
    colr_t             colr;

    display_timing u_display_timing (
        .clk_pix (clk_pix),
        .rst_pix (rst_pix),
        .sx      (sx),
        .sy      (sy),
        .sync    (sync)
    );

    wb_regs u_wb_regs (
        .clk_pix (clk_pix),
        .rst_pix (rst_pix),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .sync    (sync),
        .cfg     (cfg),
        .bmp_wr  (bmp_wr),
        .pal_wr  (pal_wr)
    );

    sprite_engine u_sprite_engine (
        .clk_pix  (clk_pix),
        .rst_pix  (rst_pix),
        .sx       (sx),
        .sy       (sy),
        .sync     (sync),
        .cfg      (cfg),
        .bmp_addr (bmp_addr),
        .draw     (draw)
    );

    sprite_bitmap u_sprite_bitmap (
        .clk_pix (clk_pix),
        .wr      (bmp_wr),
        .rd_addr (bmp_addr),
        .draw    (draw),
        .cidx    (cidx),
        .draw_q  (draw_q)
    );

    palette_clut u_palette_clut (
        .clk_pix (clk_pix),
        .wr      (pal_wr),
        .cidx    (cidx),
        .colr    (colr)
    );

    pixel_compose u_pixel_compose (
        .clk_pix (clk_pix),
        .rst_pix (rst_pix),
        .sync    (sync),
        .cfg     (cfg),
        .cidx    (cidx),
        .draw_q  (draw_q),
        .colr    (colr),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de),
        .r       (r),
        .g       (g),
        .b       (b)
    );

endmodule

// File: bench/tb_sprite_display.sv
// testbench for the sprite display: wishbone host tasks, pixel model and sync checks
// tracks x/y from the output ports alone and compares every active pixel
`include "display_params.svh"

module tb_sprite_display import sprite_pkg::*; ();

    localparam int CLK_PERIOD = 10;
    localparam int H_TOTAL    = `H_RES + `H_FP + `H_SYNC + `H_BP;   // 800
    localparam int V_TOTAL    = `V_RES + `V_FP + `V_SYNC + `V_BP;   // 525
    localparam int SPR_DW     = `SPR_W << `SPR_SCALE;              // drawn width
    localparam int SPR_DH     = `SPR_H << `SPR_SCALE;
    localparam int ACK_LIMIT  = 8;                                 // cycles before giving up on ack
    localparam int RUN_FRAMES = 4;
    localparam int WATCHDOG   = CLK_PERIOD * (5 * H_TOTAL * V_TOTAL + 20000);

    logic              clk_pix;
    logic              rst_pix;
    wb_req_t           wb_req;
    wb_rsp_t           wb_rsp;
    logic              hsync, vsync, de;
    logic [`CHANW-1:0] r, g, b;

    // host view of bitmap, palette, shadow and live config
    logic [`CIDXW-1:0] bmp_model [`SPR_W * `SPR_H];
    colr_t             pal_model [1 << `CIDXW];
    int                sh_sprx, sh_spry, lv_sprx, lv_spry;
    colr_t             sh_bg, lv_bg;
    logic [`CIDXW-1:0] sh_trans, lv_trans;

    // output tracking
    int   out_x, out_y, frame_cnt;
    int   line_cyc, hs_low, de_cnt, lines, act_lines, vs_lines;
    int   frames_timed, spr_px, clip_px;
    logic de_q, hs_q, vs_q, seen_hs, seen_vs;
    int   seed;

    sprite_display_top u_sprite_display_top (
        .clk_pix (clk_pix),
        .rst_pix (rst_pix),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de),
        .r       (r),
        .g       (g),
        .b       (b)
    );

    initial begin
        clk_pix = 1'b0;
        forever #(CLK_PERIOD / 2) clk_pix = ~clk_pix;
    end

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("[FAIL] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first mismatch");
    endtask

    // one classic access; stb held one cycle past ack to catch a second ack
    task automatic wb_access(input logic we, input logic [7:0] adr, input logic [15:0] dat,
                             output logic [15:0] rdata);
        int waited;
        @(posedge clk_pix);
        #1;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: dat};
        waited = 0;
        do begin
            @(posedge clk_pix);
            #1;
            waited++;
        end while (!wb_rsp.ack && waited < ACK_LIMIT);
        assert (wb_rsp.ack && waited == 1)
            else report_mismatch("wishbone ack delay", 1, waited);
        rdata = wb_rsp.dat_r;
        @(posedge clk_pix);
        #1;
        assert (!wb_rsp.ack) else report_mismatch("wishbone ack repeat", 0, int'(wb_rsp.ack));
        wb_req = '0;   // release bus
    endtask

    // expected colour from the sprite rules and the live config
    function automatic colr_t expect_pix(input int px, input int py);
        int                dx;
        int                dy;
        logic [`CIDXW-1:0] idx;
        dx = px - lv_sprx;
        dy = py - lv_spry;
        if (dx >= 0 && dx < SPR_DW && dy >= 0 && dy < SPR_DH) begin
            idx = bmp_model[(dy >> `SPR_SCALE) * `SPR_W + (dx >> `SPR_SCALE)];
            if (idx != lv_trans) begin
                return pal_model[idx];
            end
        end
        return lv_bg;   // outside box or transparent
    endfunction

    blank_is_black: assert property (@(posedge clk_pix) disable iff (rst_pix)
        !de |-> ({r, g, b} == '0))
        else report_mismatch("blanking colour", 0, int'({r, g, b}));

    // samples the registered outputs on every edge
    always @(posedge clk_pix) begin
        colr_t exp;
        if (rst_pix) begin
            {out_x, out_y, frame_cnt} = {32'sd0, -32'sd1, 32'sd0};
            {line_cyc, hs_low, de_cnt} = '0;
            {lines, act_lines, vs_lines} = '0;
            {frames_timed, spr_px, clip_px} = '0;
            {de_q, seen_hs, seen_vs} = '0;
            hs_q = 1'b1;
            vs_q = 1'b1;
            sh_sprx  = `H_RES;   // off screen
            sh_spry  = 0;
            sh_bg    = '0;
            sh_trans = '0;
            lv_sprx  = `H_RES;
            lv_spry  = 0;
            lv_bg    = '0;
            lv_trans = '0;
        end else begin
            line_cyc++;
            if (!hsync) hs_low++;
            if (!hsync && hs_q) begin   // hsync falling, one per line
                if (seen_hs) begin
                    assert (line_cyc == H_TOTAL)
                        else report_mismatch("line length", H_TOTAL, line_cyc);
                end
                seen_hs  = 1'b1;
                line_cyc = 0;
                lines++;
                if (!vsync) vs_lines++;
            end
            if (hsync && !hs_q) begin
                if (seen_hs) begin
                    assert (hs_low == `H_SYNC)
                        else report_mismatch("hsync width", `H_SYNC, hs_low);
                end
                hs_low = 0;
            end
            if (!vsync && vs_q) begin   // frame boundary, live config swaps here
                if (seen_vs) begin
                    assert (lines == V_TOTAL) else report_mismatch("frame lines", V_TOTAL, lines);
                    assert (act_lines == `V_RES)
                        else report_mismatch("active lines", `V_RES, act_lines);
                    assert (vs_lines == `V_SYNC)
                        else report_mismatch("vsync lines", `V_SYNC, vs_lines);
                    frames_timed++;
                end
                seen_vs = 1'b1;
                {lines, act_lines, vs_lines} = '0;
                frame_cnt++;
                out_y    = -1;
                lv_sprx  = sh_sprx;
                lv_spry  = sh_spry;
                lv_bg    = sh_bg;
                lv_trans = sh_trans;
            end
            if (de && !de_q) begin
                out_x = 0;
                out_y = out_y + 1;
                act_lines++;
            end else if (de) begin
                out_x = out_x + 1;
            end
            if (!de && de_q) begin
                assert (de_cnt == `H_RES) else report_mismatch("de per line", `H_RES, de_cnt);
                de_cnt = 0;
            end
            if (de) begin
                de_cnt++;
                exp = expect_pix(out_x, out_y);
                assert ({r, g, b} == exp)
                    else report_mismatch($sformatf("pixel f%0d (%0d,%0d)", frame_cnt, out_x,
                                         out_y), int'(exp), int'({r, g, b}));
                if (exp != lv_bg) begin
                    spr_px++;
                    if (lv_sprx < 0) clip_px++;   // left clipped sprite
                end
            end
        end
        de_q = de;
        hs_q = hsync;
        vs_q = vsync;
    end

    initial begin
        #(WATCHDOG);
        $display("timeout: the run did not reach its last frame in time");
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [15:0] rdata;
        logic [31:0] rnd;
        seed    = 32'h3afa_b91b;
        rst_pix = 1'b1;
        wb_req  = '0;
        repeat (3) @(posedge clk_pix);
        #1;
        rst_pix = 1'b0;

        wb_access(1'b0, REG_SPRX, '0, rdata);
        assert (rdata == 16'(`H_RES)) else report_mismatch("read sprx reset", `H_RES, rdata);

        // random palette and bitmap, not shadowed
        for (int i = 0; i < (1 << `CIDXW); i++) begin
            rnd          = $random(seed);
            pal_model[i] = colr_t'(rnd[`COLRW-1:0]);
            wb_access(1'b1, 8'(8'h10 + i), {4'h0, rnd[`COLRW-1:0]}, rdata);
        end
        for (int i = 0; i < `SPR_W * `SPR_H; i++) begin
            rnd          = $random(seed);
            bmp_model[i] = rnd[`CIDXW-1:0];
            wb_access(1'b1, 8'(8'h40 + i), {12'h000, rnd[`CIDXW-1:0]}, rdata);
        end
        wb_access(1'b0, 8'h13, '0, rdata);
        assert (rdata == '0) else report_mismatch("read palette window", 0, rdata);
        wb_access(1'b0, 8'h45, '0, rdata);
        assert (rdata == '0) else report_mismatch("read bitmap window", 0, rdata);

        rnd = $random(seed);
        wb_access(1'b1, REG_BG, {4'h0, rnd[`COLRW-1:0]}, rdata);
        sh_bg = colr_t'(rnd[`COLRW-1:0]);
        wb_access(1'b1, REG_TRANS, {12'h000, bmp_model[0]}, rdata);   // top-left is see-through
        sh_trans = bmp_model[0];
        wb_access(1'b0, REG_BG, '0, rdata);
        assert (rdata == {4'h0, sh_bg}) else report_mismatch("read bg", int'(sh_bg), rdata);
        wb_access(1'b0, REG_TRANS, '0, rdata);
        assert (rdata == 16'(sh_trans)) else report_mismatch("read trans", sh_trans, rdata);

        // frame 1 is background only, sprite moves in mid frame
        wait (frame_cnt == 1 && out_y == 240);
        wb_access(1'b1, REG_SPRX, 16'd100, rdata);
        wb_access(1'b1, REG_SPRY, 16'd50, rdata);
        sh_sprx = 100;
        sh_spry = 50;

        // frame 2 must keep (100,50) even though the move lands above row 50
        wait (frame_cnt == 2 && out_y == 20);
        wb_access(1'b1, REG_SPRX, 16'(-6), rdata);
        wb_access(1'b1, REG_SPRY, 16'd200, rdata);
        sh_sprx = -6;
        sh_spry = 200;
        wb_access(1'b0, REG_SPRX, '0, rdata);
        assert (rdata == 16'hfffa) else report_mismatch("read sprx", 16'hfffa, rdata);
        wb_access(1'b0, REG_SPRY, '0, rdata);
        assert (rdata == 16'd200) else report_mismatch("read spry", 200, rdata);

        wait (frame_cnt == RUN_FRAMES);
        if (frames_timed < RUN_FRAMES - 1 || spr_px == 0 || clip_px == 0) begin
            $display("not every check was reached: frames %0d, sprite %0d, clipped %0d",
                     frames_timed, spr_px, clip_px);
            $display("*** TEST FAILED ***");
            $fatal(1, "coverage of the checks incomplete");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

// File: list.f
+incdir+common
common/sprite_pkg.sv
display/display_timing.sv
source/wb_regs.sv
sprite/sprite_engine.sv
sprite/sprite_bitmap.sv
source/palette_clut.sv
source/pixel_compose.sv
source/sprite_display_top.sv
bench/tb_sprite_display.sv

// File: run.sh
#!/usr/bin/env bash
# build the sprite display testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f list.f --top-module tb_sprite_display

# exit status is nonzero when the testbench stops on $fatal
./obj_dir/Vtb_sprite_display
